//--- project.f
src/rr_arb_pkg.sv
src/arb_next_prio.sv
src/arb_lane.sv
src/arb_lane_vote.sv
src/arb_data_tree.sv
src/rr_arb_tmr.sv
verification/tb_rr_arb_tmr.sv

//--- Makefile
# Verilator lint and simulation of the redundant round-robin arbiter

TOP := tb_rr_arb_tmr

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^=== PASS ===$$'

clean:
	rm -rf obj_dir

//--- verification/tb_rr_arb_tmr.sv
// testbench for the redundant round-robin arbiter, run it as top to drive random and directed traffic
module tb_rr_arb_tmr;

  localparam int unsigned NumIn      = 8;
  localparam int unsigned DataWidth  = 16;
  localparam int unsigned IdxWidth   = 3;
  localparam int unsigned HalfPeriod = 50;
  localparam int unsigned DriveDelay = 10;
  localparam int unsigned RandCycles = 2000;

  logic                            clk_i;
  logic                            rst_ni;
  logic                            flush_i;
  logic [NumIn-1:0]                req_i;
  logic [NumIn-1:0][DataWidth-1:0] data_i;
  logic [NumIn-1:0]                gnt_o;
  logic                            req_o;
  logic                            gnt_i;
  logic [DataWidth-1:0]            data_o;
  logic [IdxWidth-1:0]             idx_o;
  logic                            fault_o;

  // model registers, upstream requests still waiting, and the random source
  logic [IdxWidth-1:0] m_rr;
  logic                m_lock;
  logic [NumIn-1:0]    m_held;
  logic [NumIn-1:0]    req_pend;
  logic [31:0]         lfsr;
  logic [IdxWidth-1:0] xfer_idx;
  int unsigned         value_errors;
  int unsigned         timeout_errors;

  rr_arb_tmr #(
    .NumIn     ( NumIn     ),
    .DataWidth ( DataWidth )
  ) DUT (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .flush_i ( flush_i ),
    .req_i   ( req_i   ),
    .data_i  ( data_i  ),
    .gnt_o   ( gnt_o   ),
    .req_o   ( req_o   ),
    .gnt_i   ( gnt_i   ),
    .data_o  ( data_o  ),
    .idx_o   ( idx_o   ),
    .fault_o ( fault_o )
  );

  always #HalfPeriod clk_i = ~clk_i;

  ////////////////////
  // model
  ////////////////////

  // galois lfsr, each returned bit costs one step
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] bits;
    bits = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      bits = {bits[30:0], lfsr[0]};
    end
    return bits;
  endfunction

  // walk from the root, halving the index range at every level
  function automatic logic [IdxWidth-1:0] tree_pick(input logic [NumIn-1:0] req,
                                                    input logic [IdxWidth-1:0] rr);
    int unsigned base;
    int unsigned half;
    logic        left_any;
    logic        right_any;
    base = 0;
    for (int unsigned level = 0; level < IdxWidth; level++) begin
      half      = NumIn >> (level + 1);
      left_any  = 1'b0;
      right_any = 1'b0;
      for (int unsigned i = 0; i < half; i++) begin
        left_any  = left_any | req[base+i];
        right_any = right_any | req[base+half+i];
      end
      // the root reads the top bit of rr
      if (!left_any || (right_any && rr[IdxWidth-1-level])) begin
        base = base + half;
      end
    end
    return base[IdxWidth-1:0];
  endfunction

  // lowest request above rr, else the lowest one at or below it
  function automatic logic [IdxWidth-1:0] next_rr(input logic [NumIn-1:0] req,
                                                  input logic [IdxWidth-1:0] rr);
    for (int i = int'(rr) + 1; i < int'(NumIn); i++) begin
      if (req[i]) return IdxWidth'(i);
    end
    for (int i = 0; i <= int'(rr); i++) begin
      if (req[i]) return IdxWidth'(i);
    end
    return rr;
  endfunction

  task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] got);
    value_errors++;
    $display("[ERROR] %0t: %s expected %0h got %0h", $time, what, exp, got);
  endtask

  // compare outputs at the falling edge, then advance the model by the coming rising edge
  task automatic check_cycle();
    logic [NumIn-1:0]    eff;
    logic                exp_req;
    logic                exp_xfer;
    logic [IdxWidth-1:0] exp_idx;
    logic [NumIn-1:0]    exp_gnt;
    eff      = m_lock ? m_held : req_i;
    exp_req  = |eff;
    exp_idx  = tree_pick(eff, m_rr);
    exp_xfer = exp_req && gnt_i;
    exp_gnt  = exp_xfer ? (NumIn'(1) << exp_idx) : '0;
    assert (req_o === exp_req) else mismatch("req_o", 32'(exp_req), 32'(req_o));
    assert (idx_o === exp_idx) else mismatch("idx_o", 32'(exp_idx), 32'(idx_o));
    assert (gnt_o === exp_gnt) else mismatch("gnt_o", 32'(exp_gnt), 32'(gnt_o));
    assert (data_o === data_i[exp_idx]) else mismatch("data_o", 32'(data_i[exp_idx]), 32'(data_o));
    assert (fault_o === 1'b0) else mismatch("fault_o", 32'h0, 32'(fault_o));
    // the grant order checks look at the requester the DUT actually granted
    xfer_idx = '0;
    for (int i = 0; i < int'(NumIn); i++) begin
      if (gnt_o[i]) xfer_idx = IdxWidth'(i);
    end
    if (flush_i) begin
      m_rr   = '0;
      m_lock = 1'b0;
      m_held = '0;
    end else begin
      if (exp_xfer) m_rr = next_rr(eff, m_rr);
      m_lock = exp_req && !gnt_i;
      m_held = eff;
    end
    // a granted requester drops its request, every other one keeps waiting
    if (exp_xfer) req_pend[exp_idx] = 1'b0;
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  task automatic drive_cycle(input logic [NumIn-1:0] new_req, input logic gnt,
                             input logic flush);
    logic [31:0] word;
    @(posedge clk_i);
    #DriveDelay;
    req_pend = req_pend | new_req;
    req_i    = req_pend;
    gnt_i    = gnt;
    flush_i  = flush;
    for (int unsigned i = 0; i < NumIn; i++) begin
      word      = take_bits(DataWidth);
      data_i[i] = word[DataWidth-1:0];
    end
    #(HalfPeriod - DriveDelay);
    check_cycle();
  endtask

  // random requests arrive with a chance of one in sixteen per requester
  function automatic logic [NumIn-1:0] random_requests();
    logic [NumIn-1:0] req;
    for (int unsigned i = 0; i < NumIn; i++) begin
      req[i] = (take_bits(4) == 32'h0);
    end
    return req;
  endfunction

  task automatic drain_pending(input int unsigned limit);
    int unsigned cycles;
    cycles = 0;
    while (req_pend != '0 && cycles < limit) begin
      drive_cycle('0, 1'b1, 1'b0);
      cycles++;
    end
    if (req_pend != '0) begin
      timeout_errors++;
      $display("timeout: requests %b still had no grant after %0d cycles", req_pend, limit);
    end
  endtask

  initial begin : p_main
    logic [IdxWidth-1:0] last;
    int unsigned         visits [NumIn];
    {clk_i, rst_ni, flush_i, gnt_i, req_i, data_i} = '0;
    {m_rr, m_lock, m_held, req_pend, xfer_idx} = '0;
    value_errors   = 0;
    timeout_errors = 0;
    lfsr           = 32'hca71_2e87;
    repeat (10) @(posedge clk_i);
    #DriveDelay rst_ni = 1'b1;

    // idle after reset, then requests pile up while the sink refuses
    repeat (3) drive_cycle('0, 1'b1, 1'b0);
    for (int n = 0; n < 20; n++) begin
      drive_cycle(random_requests(), 1'b0, 1'b0);
      assert (gnt_o === '0) else mismatch("gnt_o with gnt_i low", 32'h0, 32'(gnt_o));
    end

    // random traffic with a sink ready three cycles in four and a rare flush
    for (int n = 0; n < int'(RandCycles); n++) begin
      drive_cycle(random_requests(), take_bits(2) != 32'h0, take_bits(6) == 32'h0);
    end
    drain_pending(64);

    // the locked winner holds while newer requests show up
    drive_cycle(8'h10, 1'b0, 1'b0);
    for (int n = 0; n < 4; n++) begin
      drive_cycle(8'hef, 1'b0, 1'b0);
      assert (idx_o === 3'd4 && data_o === data_i[4])
        else mismatch("locked idx_o", 32'h4, 32'(idx_o));
    end
    drive_cycle('0, 1'b1, 1'b0);
    assert (gnt_o === 8'h10) else mismatch("gnt_o after back-pressure", 32'h10, 32'(gnt_o));
    drain_pending(64);

    // full load from a flushed lock visits every index in order
    drive_cycle(8'h22, 1'b0, 1'b0);
    drive_cycle('0, 1'b0, 1'b1);
    visits = '{default: 0};
    for (int n = 0; n < 16; n++) begin
      drive_cycle(8'hff, 1'b1, 1'b0);
      if (n == 0) begin
        assert (xfer_idx == '0)
          else mismatch("first grant after flush", 32'h0, 32'(xfer_idx));
      end else begin
        assert (xfer_idx == IdxWidth'(last + 1'b1))
          else mismatch("full load grant order", 32'(IdxWidth'(last + 1'b1)), 32'(xfer_idx));
      end
      last = xfer_idx;
      visits[xfer_idx]++;
    end
    for (int i = 0; i < int'(NumIn); i++) begin
      assert (visits[i] == 2) else mismatch("grants per index", 32'h2, 32'(visits[i]));
    end
    drain_pending(64);

    // a sparse set, once rr sits on a requester each grant moves to the next one up
    for (int n = 0; n < 12; n++) begin
      drive_cycle(8'ha4, 1'b1, 1'b0);
      if (n >= 2) begin
        assert (xfer_idx == next_rr(8'ha4, last))
          else mismatch("sparse grant order", 32'(next_rr(8'ha4, last)), 32'(xfer_idx));
      end
      last = xfer_idx;
    end
    drain_pending(64);

    $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- src/rr_arb_tmr.sv
// top level of the triple redundant round-robin arbiter, instantiate it between requesters and sink
module rr_arb_tmr #(
  parameter int unsigned NumIn     = rr_arb_pkg::NumInDefault,
  parameter int unsigned DataWidth = rr_arb_pkg::DataWidthDefault
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  logic [NumIn-1:0]              req_i,
  input  logic [NumIn-1:0][DataWidth-1:0] data_i,
  output logic [NumIn-1:0]              gnt_o,
  output logic                          req_o,
  input  logic                          gnt_i,
  output logic [DataWidth-1:0]          data_o,
  output rr_arb_pkg::idx_t              idx_o,
  output logic                          fault_o
);

  import rr_arb_pkg::*;

  localparam int unsigned NumSel = 2 ** $clog2(NumIn) - 1;

  // per lane state and decision, plus the two peer copies each lane votes against
  arb_state_t [NumLanes-1:0]      lane_state;
  arb_state_t [NumLanes-1:0][1:0] peer_state;
  lane_out_t  [NumLanes-1:0]      lane_out;
  logic       [NumSel-1:0]        sel_voted;

  ////////////////////
  // lanes
  ////////////////////

  for (genvar i = 0; i < NumLanes; i++) begin : gen_lanes
    // lane i sees lanes i+1 and i+2 in rotated order
    for (genvar j = 0; j < 2; j++) begin : gen_peers
      assign peer_state[i][j] = lane_state[(i+j+1)%NumLanes];
    end

    // every lane reads the top level handshake directly
    arb_lane #(
      .NumIn ( NumIn )
    ) i_lane (
      .clk_i        ( clk_i         ),
      .rst_ni       ( rst_ni        ),
      .flush_i      ( flush_i       ),
      .req_i        ( req_i         ),
      .gnt_i        ( gnt_i         ),
      .peer_state_i ( peer_state[i] ),
      .state_o      ( lane_state[i] ),
      .lane_o       ( lane_out[i]   )
    );
  end

  ////////////////////
  // vote and data path
  ////////////////////

  arb_lane_vote #(
    .NumIn ( NumIn )
  ) i_vote (
    .lanes_i ( lane_out  ),
    .gnt_o   ( gnt_o     ),
    .req_o   ( req_o     ),
    .idx_o   ( idx_o     ),
    .sel_o   ( sel_voted ),
    .fault_o ( fault_o   )
  );

  // only the selects are triplicated, the wide payload goes through a single mux tree
  arb_data_tree #(
    .NumIn     ( NumIn     ),
    .DataWidth ( DataWidth )
  ) i_data_tree (
    .sel_i  ( sel_voted ),
    .data_i ( data_i    ),
    .data_o ( data_o    )
  );

  // the lane structs are sized for the default requester count
  initial begin : p_param_check
    assert (NumIn == NumInDefault)
      else $fatal(1, "NumIn must match the package requester count");
  end

  // with requests held until granted the output request mirrors the input requests
  a_req_follows : assert property (
    @(posedge clk_i) disable iff (!rst_ni || flush_i) req_o == (|req_i))
    else $error("req_o does not follow req_i");

endmodule

//--- src/arb_data_tree.sv
// payload multiplexer tree that follows the voted node selects from the leaves to the root
module arb_data_tree #(
  parameter int unsigned NumIn     = rr_arb_pkg::NumInDefault,
  parameter int unsigned DataWidth = rr_arb_pkg::DataWidthDefault,
  localparam int unsigned NumSel   = 2 ** $clog2(NumIn) - 1
) (
  input  logic [NumSel-1:0]               sel_i,
  input  logic [NumIn-1:0][DataWidth-1:0] data_i,
  output logic [DataWidth-1:0]            data_o
);

  localparam int unsigned NumLevels = $clog2(NumIn);
  localparam int unsigned NumLeaves = 2 ** NumLevels;

  // payloads padded to a full tree and the value carried by each node
  logic [NumLeaves-1:0][DataWidth-1:0] data_pad;
  logic [NumSel-1:0][DataWidth-1:0]    data_nodes;

  // leaves beyond the last requester carry zero
  for (genvar i = 0; i < NumLeaves; i++) begin : gen_pad
    if (i < NumIn) begin : gen_in_range
      assign data_pad[i] = data_i[i];
    end else begin : gen_out_of_range
      assign data_pad[i] = '0;
    end
  end

  ////////////////////
  // mux levels
  ////////////////////

  // same node numbering as the lanes so each select lands on its own mux
  for (genvar level = 0; level < NumLevels; level++) begin : gen_levels
    for (genvar l = 0; l < 2 ** level; l++) begin : gen_nodes
      localparam int unsigned Idx0 = 2 ** level - 1 + l;
      localparam int unsigned Idx1 = 2 ** (level + 1) - 1 + l * 2;

      if (level == NumLevels - 1) begin : gen_leaf
        // bottom level picks between two neighbouring payloads
        assign data_nodes[Idx0] = sel_i[Idx0] ? data_pad[l*2+1] : data_pad[l*2];
      end else begin : gen_inner
        // upper levels pick between the two child muxes
        assign data_nodes[Idx0] = sel_i[Idx0] ? data_nodes[Idx1+1] : data_nodes[Idx1];
      end
    end
  end

  // the root holds the payload of the granted requester
  assign data_o = data_nodes[0];

endmodule

//--- src/arb_lane_vote.sv
// majority vote over the three lane decisions with a flag for any lane disagreement
module arb_lane_vote #(
  parameter int unsigned NumIn  = rr_arb_pkg::NumInDefault,
  localparam int unsigned NumSel = 2 ** $clog2(NumIn) - 1
) (
  input  rr_arb_pkg::lane_out_t [2:0] lanes_i,
  output logic [NumIn-1:0]            gnt_o,
  output logic                        req_o,
  output rr_arb_pkg::idx_t            idx_o,
  output logic [NumSel-1:0]           sel_o,
  output logic                        fault_o
);

  import rr_arb_pkg::*;

  lane_out_t  voted;
  logic [3:0] field_diff;

  // the struct is voted as one vector so every field gets the same bitwise majority
  assign voted = maj3(lanes_i[0], lanes_i[1], lanes_i[2]);

  assign req_o = voted.req;
  assign gnt_o = voted.gnt;
  assign idx_o = voted.idx;
  assign sel_o = voted.sel;

  ////////////////////
  // fault detection
  ////////////////////

  // one bit per field so a waveform shows where the lanes split
  always_comb begin : p_field_diff
    field_diff[0] = (lanes_i[0].req != lanes_i[1].req) ||
                    (lanes_i[1].req != lanes_i[2].req);
    field_diff[1] = (lanes_i[0].gnt != lanes_i[1].gnt) ||
                    (lanes_i[1].gnt != lanes_i[2].gnt);
    field_diff[2] = (lanes_i[0].idx != lanes_i[1].idx) ||
                    (lanes_i[1].idx != lanes_i[2].idx);
    field_diff[3] = (lanes_i[0].sel != lanes_i[1].sel) ||
                    (lanes_i[1].sel != lanes_i[2].sel);
  end

  // any single mismatch is worth reporting even though the vote masks it
  assign fault_o = |field_diff;

  // voted grant and voted index must still point at the same requester
  always_comb begin : p_gnt_idx_check
    a_gnt_idx : assert final (!(req_o && (|gnt_o)) || (gnt_o[idx_o] && $onehot(gnt_o)))
      else $error("voted grant does not match voted index");
  end

endmodule

//--- src/arb_lane.sv
// one redundant arbitration lane with peer voted state registers and the request/grant tree
module arb_lane #(
  parameter int unsigned NumIn = rr_arb_pkg::NumInDefault
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  input  logic [NumIn-1:0]             req_i,
  input  logic                         gnt_i,
  input  rr_arb_pkg::arb_state_t [1:0] peer_state_i,
  output rr_arb_pkg::arb_state_t       state_o,
  output rr_arb_pkg::lane_out_t        lane_o
);

  import rr_arb_pkg::*;

  // tree geometry, padded up to a full binary tree
  localparam int unsigned NumLevels = $clog2(NumIn);
  localparam int unsigned NumLeaves = 2 ** NumLevels;
  localparam int unsigned NumNodes  = NumLeaves - 1;

  // zero bits that widen the state to the vote width
  localparam int unsigned StateBits = $bits(arb_state_t);
  localparam int unsigned PadBits   = VoteWidth - StateBits;

  arb_state_t state_q;
  arb_state_t state_d;
  arb_state_t state_v;
  vote_t      state_vote;

  logic [NumIn-1:0]     req_eff;
  logic [NumLeaves-1:0] req_pad;
  logic [NumLeaves-1:0] gnt_pad;
  logic [NumNodes-1:0]  req_nodes;
  logic [NumNodes-1:0]  sel_nodes;
  logic [NumNodes-1:0]  gnt_nodes;
  idx_t                 idx_path;
  idx_t                 rr_next;

  ////////////////////
  // state and voting
  ////////////////////

  // this lane's own copy of the state, shared with both peers
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state_reg
    if (!rst_ni) begin
      state_q <= '0;
    end else if (flush_i) begin
      state_q <= '0;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

  // a single upset register is outvoted by the two peer copies
  assign state_vote = maj3({{PadBits{1'b0}}, state_q},
                           {{PadBits{1'b0}}, peer_state_i[0]},
                           {{PadBits{1'b0}}, peer_state_i[1]});
  assign state_v    = state_vote[StateBits-1:0];

  // while locked the tree keeps seeing the request set it decided on
  assign req_eff = state_v.lock ? state_v.req_held : req_i;

  arb_next_prio #(
    .NumIn ( NumIn )
  ) i_next_prio (
    .req_i  ( req_eff    ),
    .rr_i   ( state_v.rr ),
    .next_o ( rr_next    )
  );

  always_comb begin : p_state_next
    // lock stays set as long as the output request waits for its grant
    state_d.lock     = lane_o.req & ~gnt_i;
    state_d.req_held = req_eff;
    // priority only moves on a completed transfer
    state_d.rr       = (lane_o.req && gnt_i) ? rr_next : state_v.rr;
  end

  ////////////////////
  // request/grant tree
  ////////////////////

  // leaves past the last requester never request
  assign req_pad      = NumLeaves'(req_eff);
  assign gnt_nodes[0] = gnt_i;

  for (genvar level = 0; level < NumLevels; level++) begin : gen_levels
    for (genvar l = 0; l < 2 ** level; l++) begin : gen_nodes
      // node index and index of its left child in the flat node vector
      localparam int unsigned Idx0 = 2 ** level - 1 + l;
      localparam int unsigned Idx1 = 2 ** (level + 1) - 1 + l * 2;

      logic left_req;
      logic right_req;

      if (level == NumLevels - 1) begin : gen_leaf
        assign left_req  = req_pad[l*2];
        assign right_req = req_pad[l*2+1];
        // a left grant already implies a left request because the select was low
        assign gnt_pad[l*2]   = gnt_nodes[Idx0] & ~sel_nodes[Idx0];
        assign gnt_pad[l*2+1] = gnt_nodes[Idx0] & sel_nodes[Idx0] & right_req;
      end else begin : gen_inner
        assign left_req  = req_nodes[Idx1];
        assign right_req = req_nodes[Idx1+1];
        assign gnt_nodes[Idx1]   = gnt_nodes[Idx0] & ~sel_nodes[Idx0];
        assign gnt_nodes[Idx1+1] = gnt_nodes[Idx0] & sel_nodes[Idx0];
      end

      assign req_nodes[Idx0] = left_req | right_req;
      // go right when left is idle or when both request and this level's rr bit is set
      // the root looks at the top bit of rr and the leaves at the bottom bit
      assign sel_nodes[Idx0] = ~left_req | (right_req & state_v.rr[NumLevels-1-level]);
    end
  end

  // the winning index is the chain of selects from the root down
  always_comb begin : p_idx_path
    int unsigned node;
    node     = 0;
    idx_path = '0;
    for (int unsigned level = 0; level < NumLevels; level++) begin
      idx_path[NumLevels-1-level] = sel_nodes[node];
      node = 2 * node + 1 + int'(sel_nodes[node]);
    end
  end

  assign lane_o.req = req_nodes[0];
  assign lane_o.gnt = gnt_pad[NumIn-1:0];
  assign lane_o.idx = idx_path;
  assign lane_o.sel = sel_nodes;

  ////////////////////
  // checks
  ////////////////////

  // the tree hands out at most one grant per cycle
  a_gnt_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni || flush_i) $onehot0(lane_o.gnt))
    else $error("lane grant is not one-hot or zero");

  // a request left waiting keeps its winner on the next cycle
  a_lock_idx : assert property (
    @(posedge clk_i) disable iff (!rst_ni || flush_i)
    (lane_o.req && !gnt_i) |=> (lane_o.idx == $past(lane_o.idx)))
    else $error("lane index changed while locked");

endmodule

//--- src/arb_next_prio.sv
// fair next priority for one lane, the lowest request above rr or else the wrapped lowest request
module arb_next_prio #(
  parameter int unsigned NumIn = rr_arb_pkg::NumInDefault
) (
  input  logic [NumIn-1:0]  req_i,
  input  rr_arb_pkg::idx_t  rr_i,
  output rr_arb_pkg::idx_t  next_o
);

  import rr_arb_pkg::*;

  // requests split into those served after rr in this round and those that wrap around
  logic [NumIn-1:0] upper_mask;
  logic [NumIn-1:0] lower_mask;
  idx_t             upper_idx;
  idx_t             lower_idx;

  // trailing zero search over one mask
  // an empty mask gives index zero, the caller checks for emptiness itself
  function automatic idx_t lowest_set(input logic [NumIn-1:0] vec);
    idx_t pos;
    pos = '0;
    // walk from the top so the lowest set bit is written last
    for (int i = NumIn - 1; i >= 0; i--) begin
      if (vec[i]) begin
        pos = idx_t'(i);
      end
    end
    return pos;
  endfunction

  always_comb begin : p_mask
    for (int unsigned i = 0; i < NumIn; i++) begin
      // indices strictly above rr get the next turn
      upper_mask[i] = (i > rr_i) ? req_i[i] : 1'b0;
      // rr itself and everything below only win after the wrap
      lower_mask[i] = (i <= rr_i) ? req_i[i] : 1'b0;
    end
  end

  assign upper_idx = lowest_set(upper_mask);
  assign lower_idx = lowest_set(lower_mask);

  // the upper group always wins when it holds a request
  assign next_o = (|upper_mask) ? upper_idx : lower_idx;

endmodule

//--- src/rr_arb_pkg.sv
// shared sizes, lane state and result types, and the majority vote used by the arbitration tree
package rr_arb_pkg;

  ////////////////////
  // sizes
  ////////////////////

  // default number of requesters and payload width of the tree
  localparam int unsigned NumInDefault     = 8;
  localparam int unsigned DataWidthDefault = 16;

  // the majority vote only works for three copies
  localparam int unsigned NumLanes = 3;

  // width of a requester index and number of tree nodes above the leaves
  localparam int unsigned IdxWidth = $clog2(NumInDefault);
  localparam int unsigned NumSel   = 2 ** IdxWidth - 1;

  typedef logic [IdxWidth-1:0] idx_t;

  ////////////////////
  // lane types
  ////////////////////

  // registered state of one lane, which the peers read back for voting
  typedef struct packed {
    logic                    lock;
    logic [NumInDefault-1:0] req_held;
    idx_t                    rr;
  } arb_state_t;

  // combinational decision of one lane before the output vote
  typedef struct packed {
    logic                    req;
    logic [NumInDefault-1:0] gnt;
    idx_t                    idx;
    logic [NumSel-1:0]       sel;
  } lane_out_t;

  // the vote runs on the widest voted value and narrower values are zero extended
  localparam int unsigned VoteWidth = $bits(lane_out_t);

  typedef logic [VoteWidth-1:0] vote_t;

  // each result bit follows at least two of the three inputs
  function automatic vote_t maj3(input vote_t a, input vote_t b, input vote_t c);
    return (a & b) | (a & c) | (b & c);
  endfunction

endpackage
